//--- dv/sdram_ctrl_model.sv
module sdram_ctrl_model (
  input  logic                                clk,
  input  logic                                sys_rst_n,
  input  logic                                ctrl_rd_req,
  input  logic                                ctrl_wr_req,
  input  logic [sdram_addr_pkg::addr_w-1:0]   ctrl_addr,
  input  logic [sdram_ctrl_pkg::burst_w-1:0]  ctrl_burst,
  input  logic [sdram_ctrl_pkg::data_w-1:0]   ctrl_din,
  output logic                                ctrl_rd_ack,
  output logic                                ctrl_wr_ack,
  output logic [sdram_ctrl_pkg::data_w-1:0]   ctrl_dout
);

  typedef enum logic [1:0] {st_idle, st_wait, st_beat} state_t;

  logic [sdram_ctrl_pkg::data_w-1:0] mem [logic [sdram_addr_pkg::addr_w-1:0]];
  state_t                             state;
  logic                               req_low;  // request seen low for a cycle
  logic [3:0]                         lat_cnt;
  logic [sdram_ctrl_pkg::burst_w-1:0] beat;
  logic [sdram_ctrl_pkg::burst_w-1:0] burst;
  logic [sdram_addr_pkg::addr_w-1:0]  base;
  logic                               is_rd;

  // unwritten words hold a pattern built from the whole address
  function automatic logic [15:0] stored_word(input logic [19:0] a);
    if (mem.exists(a)) begin
      return mem[a];
    end
    return {a[3:0], a[15:4]} ^ {a[19:16], 12'h3c5};
  endfunction

  always @(posedge clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      state       <= st_idle;
      req_low     <= 1'b0;
      lat_cnt     <= '0;
      beat        <= '0;
      burst       <= '0;
      base        <= '0;
      is_rd       <= 1'b0;
      ctrl_rd_ack <= 1'b0;
      ctrl_wr_ack <= 1'b0;
      ctrl_dout   <= '0;
    end else begin
      case (state)
        st_idle: begin
          req_low <= !ctrl_rd_req && !ctrl_wr_req;
          if (req_low && (ctrl_rd_req || ctrl_wr_req)) begin
            base    <= ctrl_addr;
            burst   <= ctrl_burst;
            is_rd   <= ctrl_rd_req;
            lat_cnt <= 4'($urandom % 8);  // 2 to 9 cycles to first ack
            state   <= st_wait;
          end
        end
        st_wait: begin
          if (lat_cnt == 4'd0) begin
            beat        <= '0;
            ctrl_rd_ack <= is_rd;
            ctrl_wr_ack <= !is_rd;
            if (is_rd) begin
              ctrl_dout <= stored_word(base);
            end
            state <= st_beat;
          end else begin
            lat_cnt <= lat_cnt - 4'd1;
          end
        end
        default: begin
          if (!is_rd) begin
            mem[base + 20'(beat)] = ctrl_din;
          end
          if (beat == burst - 5'd1) begin
            ctrl_rd_ack <= 1'b0;
            ctrl_wr_ack <= 1'b0;
            req_low     <= 1'b0;
            state       <= st_idle;
          end else begin
            beat <= beat + 5'd1;
            if (is_rd) begin
              ctrl_dout <= stored_word(base + 20'(beat) + 20'd1);
            end
          end
        end
      endcase
    end
  end

endmodule

//--- dv/sdram_port_assertions.sv
module sdram_port_assertions (
  input logic        clk,
  input logic        sys_rst_n,
  input logic        read_req,
  input logic        read_ack,
  input logic        write_en,
  input logic        write_latch_address,
  input logic [19:0] address,
  input logic [19:0] write_address,
  input logic        block_req,
  input logic        ctrl_rd_req,
  input logic        ctrl_wr_req
);

  logic [3:0]  cur_off;
  int unsigned fail_count = 0;  // failed checks so far

  assign cur_off = write_latch_address ? address[3:0] : write_address[3:0];

  // no second block may complete while the first is still queued
  assert property (@(posedge clk) disable iff (!sys_rst_n)
    !(block_req && write_en && cur_off == 4'hf))
    else begin
      $error("stream block completed while block_req still high");
      fail_count++;
    end

  assert property (@(posedge clk) disable iff (!sys_rst_n)
    !(ctrl_rd_req && ctrl_wr_req))
    else begin
      $error("controller read and write requested together");
      fail_count++;
    end

  assert property (@(posedge clk) disable iff (!sys_rst_n)
    $fell(read_ack) |-> $past(!read_req))
    else begin
      $error("read_ack dropped while read_req still high");
      fail_count++;
    end

endmodule

bind sdram_port_top sdram_port_assertions u_assertions (
  .clk                 (clk),
  .sys_rst_n           (sys_rst_n),
  .read_req            (read_req),
  .read_ack            (read_ack),
  .write_en            (write_en),
  .write_latch_address (write_latch_address),
  .address             (address),
  .write_address       (write_address),
  .block_req           (u_stream.block_req),
  .ctrl_rd_req         (ctrl_rd_req),
  .ctrl_wr_req         (ctrl_wr_req)
);

//--- dv/tb_sdram_port.sv
module tb_sdram_port;

  localparam int wait_limit = 200;

  logic        clk;
  logic        sys_rst_n;
  logic [19:0] address;
  logic [15:0] data_in;
  logic        read_req;
  logic        read_ack;
  logic [15:0] data_out;
  logic        write_req;
  logic        write_ack;
  logic        write_latch_address;
  logic        write_en;
  logic [19:0] write_address;
  logic        busy;
  logic        ctrl_rd_req;
  logic        ctrl_wr_req;
  logic [19:0] ctrl_addr;
  logic [4:0]  ctrl_burst;
  logic [15:0] ctrl_din;
  logic        ctrl_rd_ack;
  logic        ctrl_wr_ack;
  logic [15:0] ctrl_dout;

  logic [15:0] shadow [logic [19:0]];
  logic [15:0] exp_word;
  int          reads_issued = 0;
  int          reads_checked = 0;
  int          cmp_errors = 0;
  int          tb_errors = 0;
  int          tb_checks = 0;
  int          rd_rises = 0;
  int          wr_block_rises = 0;
  logic [19:0] last_rd_addr;
  logic [4:0]  last_rd_burst;
  logic        rd_prev = 1'b0;
  logic        wr_prev = 1'b0;

  sdram_port_top u_dut (.*);

  sdram_ctrl_model u_ctrl (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // expected memory word, from the writes issued so far
  function automatic logic [15:0] expected_word(input logic [19:0] a);
    if (shadow.exists(a)) begin
      return shadow[a];
    end
    return {a[3:0], a[15:4]} ^ {a[19:16], 12'h3c5};  // model power-up pattern
  endfunction

  always @(negedge clk) begin
    if (read_ack && reads_checked != reads_issued) begin
      reads_checked <= reads_checked + 1;
      assert (data_out === exp_word) else begin
        $display("CHECK FAILED at %0t: data_out got %h expected %h", $time, data_out, exp_word);
        cmp_errors <= cmp_errors + 1;
      end
    end
  end

  // controller port request counting
  always @(negedge clk) begin
    rd_prev <= ctrl_rd_req;
    wr_prev <= ctrl_wr_req;
    if (ctrl_rd_req && !rd_prev) begin
      rd_rises      <= rd_rises + 1;
      last_rd_addr  <= ctrl_addr;
      last_rd_burst <= ctrl_burst;
    end
    if (ctrl_wr_req && !wr_prev && ctrl_burst == 5'd16) begin
      wr_block_rises <= wr_block_rises + 1;
    end
  end

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    tb_checks++;
    assert (got === exp) else begin
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
      tb_errors++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout at %0t while waiting for %s", $time, what);
    tb_errors++;
  endtask

  task automatic single_write(input logic [19:0] a, input logic [15:0] d);
    int n;
    @(posedge clk);
    address   <= a;
    data_in   <= d;
    write_req <= 1'b1;
    n = 0;
    @(negedge clk);
    while (!write_ack && n < wait_limit) begin
      @(negedge clk);
      n++;
    end
    if (!write_ack) report_timeout("write_ack");
    shadow[a] = d;
    @(posedge clk);
    write_req <= 1'b0;
    @(posedge clk);
  endtask

  task automatic user_read(input logic [19:0] a);
    int n;
    @(posedge clk);
    exp_word = expected_word(a);
    reads_issued++;
    address  <= a;
    read_req <= 1'b1;
    n = 0;
    @(negedge clk);
    while (!read_ack && n < wait_limit) begin
      @(negedge clk);
      n++;
    end
    if (!read_ack) report_timeout("read_ack");
    @(posedge clk);
    read_req <= 1'b0;
    n = 0;
    @(negedge clk);
    while (read_ack && n < wait_limit) begin
      @(negedge clk);
      n++;
    end
    if (read_ack) report_timeout("read_ack to fall");
  endtask

  task automatic wait_block_written();
    int n;
    n = 0;
    while (!busy && n < wait_limit) begin
      @(negedge clk);
      n++;
    end
    if (!busy) report_timeout("busy to rise");
    n = 0;
    while (busy && n < wait_limit) begin
      @(negedge clk);
      n++;
    end
    if (busy) report_timeout("busy to fall");
    repeat (2) @(posedge clk);  // block_req clears after the done pulse
  endtask

  task automatic stream_block(input logic [19:0] start, input logic latch);
    logic [15:0] d;
    for (int i = 0; i < 16; i++) begin
      @(posedge clk);
      d = 16'($urandom);
      write_en            <= 1'b1;
      write_latch_address <= latch && i == 0;
      address             <= start;
      data_in             <= d;
      shadow[start + 20'(i)] = d;
    end
    @(posedge clk);
    write_en            <= 1'b0;
    write_latch_address <= 1'b0;
    @(negedge clk);
    wait_block_written();
  endtask

  task automatic end_test(input string name, input int errs_before);
    #1;
    if (tb_errors + cmp_errors == errs_before) $display("test %s: ok", name);
    else $display("test %s: %0d errors", name, tb_errors + cmp_errors - errs_before);
  endtask

  initial begin
    int e;
    int rb;
    int total;
    logic [19:0] a;
    void'($urandom(32'h745a));
    sys_rst_n = 1'b0;
    address = '0;
    data_in = '0;
    read_req = 1'b0;
    write_req = 1'b0;
    write_latch_address = 1'b0;
    write_en = 1'b0;
    repeat (3) @(posedge clk);
    sys_rst_n <= 1'b1;

    e = 0;
    @(negedge clk);
    check_value("read_ack", 32'(read_ack), 32'd0);
    check_value("write_ack", 32'(write_ack), 32'd0);
    check_value("busy", 32'(busy), 32'd0);
    check_value("ctrl_rd_req", 32'(ctrl_rd_req), 32'd0);
    check_value("ctrl_wr_req", 32'(ctrl_wr_req), 32'd0);
    check_value("write_address", 32'(write_address), 32'd0);
    end_test("reset", e);

    e = tb_errors + cmp_errors;
    single_write(20'h00046, 16'($urandom));
    rb = rd_rises;
    user_read(20'h00046);
    #1;
    check_value("ctrl_rd_req rises", 32'(rd_rises), 32'(rb + 1));
    check_value("ctrl_addr", 32'(last_rd_addr), 32'h00044);  // line aligned
    check_value("ctrl_burst", 32'(last_rd_burst), 32'd4);
    end_test("write then read miss", e);

    e = tb_errors + cmp_errors;
    rb = rd_rises;
    user_read(20'h00045);
    #1;
    check_value("ctrl_rd_req rises", 32'(rd_rises), 32'(rb));
    end_test("line hit", e);

    e = tb_errors + cmp_errors;
    rb = wr_block_rises;
    stream_block(20'h00100, 1'b1);
    stream_block(20'h00110, 1'b0);
    check_value("write_address", 32'(write_address), 32'h00120);
    check_value("burst-16 writes", 32'(wr_block_rises), 32'(rb + 2));
    user_read(20'h00105);
    user_read(20'h0011b);
    end_test("stream two blocks", e);

    e = tb_errors + cmp_errors;
    user_read(20'h00081);
    single_write(20'h00081, 16'($urandom));
    rb = rd_rises;
    user_read(20'h00081);
    #1;
    check_value("ctrl_rd_req rises", 32'(rd_rises), 32'(rb + 1));
    end_test("invalidation", e);

    e = tb_errors + cmp_errors;
    for (int k = 0; k < 40; k++) begin
      a = 20'(32'h200 + $urandom % 32);
      if ($urandom % 2 == 0) single_write(a, 16'($urandom));
      else user_read(a);
    end
    end_test("random mix", e);

    #1;
    total = tb_errors + cmp_errors + int'(u_dut.u_assertions.fail_count);
    $display("tests 6, checks %0d, errors %0d", tb_checks + reads_checked, total);
    if (total == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the SDRAM port testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_sdram_port \
  -f sdram_port.f --Mdir obj_dir -o tb_sdram_port
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out="$(./obj_dir/tb_sdram_port)"
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "RESULT: PASS"; then
  exit 0
fi
exit 1

//--- sdram_port.f
src/sdram_addr_pkg.sv
src/sdram_ctrl_pkg.sv
src/read_line_cache.sv
src/stream_write_buffer.sv
src/burst_sequencer.sv
src/sdram_port_top.sv
dv/sdram_ctrl_model.sv
dv/sdram_port_assertions.sv
dv/tb_sdram_port.sv

//--- src/burst_sequencer.sv
module burst_sequencer (
  input  logic                                    clk,
  input  logic                                    sys_rst_n,
  input  sdram_addr_pkg::user_addr_t              address,
  input  logic [sdram_ctrl_pkg::data_w-1:0]       data_in,
  input  logic                                    write_req,
  output logic                                    write_ack,
  input  logic                                    line_fill_req,
  output logic                                    line_fill_done,
  output logic                                    fill_we,
  output logic [sdram_addr_pkg::line_off_w-1:0]   fill_index,
  output logic [sdram_ctrl_pkg::data_w-1:0]       fill_data,
  input  logic                                    block_req,
  input  logic [sdram_addr_pkg::block_num_w-1:0]  block_addr,
  output logic [sdram_addr_pkg::block_off_w-1:0]  beat_index,
  input  logic [sdram_ctrl_pkg::data_w-1:0]       beat_data,
  output logic                                    block_done,
  output logic                                    busy,
  output logic                                    ctrl_rd_req,
  output logic                                    ctrl_wr_req,
  output logic [sdram_addr_pkg::addr_w-1:0]       ctrl_addr,
  output logic [sdram_ctrl_pkg::burst_w-1:0]      ctrl_burst,
  output logic [sdram_ctrl_pkg::data_w-1:0]       ctrl_din,
  input  logic                                    ctrl_rd_ack,
  input  logic                                    ctrl_wr_ack,
  input  logic [sdram_ctrl_pkg::data_w-1:0]       ctrl_dout
);

  logic [sdram_ctrl_pkg::beat_w-1:0] beat_cnt;
  logic                              write_req_last;
  logic                              single_pending;
  logic                              job_block;
  logic                              start_ok;
  logic                              start_fill;
  logic                              start_single;
  logic                              start_block;
  logic                              ack;
  logic                              last_beat;

  // requesters still see their done pulse for one cycle, so wait it out
  assign start_ok     = !busy && !line_fill_done && !block_done;
  assign start_fill   = start_ok && line_fill_req;
  assign start_single = start_ok && !line_fill_req && single_pending;
  assign start_block  = start_ok && !line_fill_req && !single_pending && block_req;

  assign ack       = ctrl_rd_ack || ctrl_wr_ack;
  assign last_beat = busy && ack && (beat_cnt == ctrl_burst - 1'b1);

  assign fill_we    = ctrl_rd_req && ctrl_rd_ack;
  assign fill_index = beat_cnt[sdram_addr_pkg::line_off_w-1:0];
  assign fill_data  = ctrl_dout;
  assign beat_index = beat_cnt[sdram_addr_pkg::block_off_w-1:0];
  assign ctrl_din   = job_block ? beat_data : data_in;  // beat 0 shown with the request

  always_ff @(posedge clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      write_req_last <= 1'b0;
      single_pending <= 1'b0;
      busy           <= 1'b0;
      job_block      <= 1'b0;
      beat_cnt       <= '0;
      ctrl_rd_req    <= 1'b0;
      ctrl_wr_req    <= 1'b0;
      write_ack      <= 1'b0;
      line_fill_done <= 1'b0;
      block_done     <= 1'b0;
    end else begin
      write_req_last <= write_req;
      write_ack      <= 1'b0;
      line_fill_done <= 1'b0;
      block_done     <= 1'b0;
      if (write_req && !write_req_last) begin
        single_pending <= 1'b1;
      end
      if (start_fill || start_single || start_block) begin
        busy        <= 1'b1;
        beat_cnt    <= '0;
        job_block   <= start_block;
        ctrl_rd_req <= start_fill;
        ctrl_wr_req <= !start_fill;
      end else if (busy && ack) begin
        beat_cnt <= beat_cnt + 1'b1;
        if (last_beat) begin
          busy        <= 1'b0;
          ctrl_rd_req <= 1'b0;
          ctrl_wr_req <= 1'b0;
          if (ctrl_rd_req) begin
            line_fill_done <= 1'b1;
          end else if (job_block) begin
            block_done <= 1'b1;
          end else begin
            write_ack      <= 1'b1;
            single_pending <= 1'b0;
          end
        end
      end
    end
  end

  // address and length latched per job
  always_ff @(posedge clk) begin
    if (start_fill) begin
      ctrl_addr  <= {address.line.tag, {sdram_addr_pkg::line_off_w{1'b0}}};
      ctrl_burst <= sdram_ctrl_pkg::burst_line;
    end else if (start_single) begin
      ctrl_addr  <= address;
      ctrl_burst <= sdram_ctrl_pkg::burst_single;
    end else if (start_block) begin
      ctrl_addr  <= {block_addr, {sdram_addr_pkg::block_off_w{1'b0}}};
      ctrl_burst <= sdram_ctrl_pkg::burst_block;
    end
  end

endmodule

//--- src/read_line_cache.sv
module read_line_cache (
  input  logic                                 clk,
  input  logic                                 sys_rst_n,
  input  sdram_addr_pkg::user_addr_t           address,
  input  logic                                 read_req,
  input  logic                                 write_req,
  input  logic                                 write_en,
  input  logic                                 fill_we,
  input  logic [sdram_addr_pkg::line_off_w-1:0] fill_index,
  input  logic [sdram_ctrl_pkg::data_w-1:0]    fill_data,
  input  logic                                 line_fill_done,
  output logic                                 line_fill_req,
  output logic                                 read_ack,
  output logic [sdram_ctrl_pkg::data_w-1:0]    data_out
);

  logic [sdram_ctrl_pkg::data_w-1:0] line_mem [sdram_addr_pkg::line_words];
  logic [sdram_addr_pkg::tag_w-1:0]  line_tag;
  logic                              line_valid;
  logic                              read_req_last;
  logic                              read_start;
  logic                              hit;

  assign read_start = read_req && !read_req_last;  // rising edge
  assign hit        = line_valid && (line_tag == address.line.tag);

  // line words and tag, filled by the sequencer
  always_ff @(posedge clk) begin
    if (fill_we) begin
      line_mem[fill_index] <= fill_data;
    end
    if (line_fill_done) begin
      line_tag <= address.line.tag;
    end
  end

  always_ff @(posedge clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      read_req_last <= 1'b0;
      line_valid    <= 1'b0;
      line_fill_req <= 1'b0;
      read_ack      <= 1'b0;
      data_out      <= '0;
    end else begin
      read_req_last <= read_req;
      if (read_start) begin
        if (hit) begin
          read_ack <= 1'b1;
          data_out <= line_mem[address.line.off];
        end else begin
          line_valid    <= 1'b0;
          line_fill_req <= 1'b1;  // held until fill done
        end
      end else if (line_fill_done) begin
        // last beat already landed in line_mem
        line_fill_req <= 1'b0;
        line_valid    <= 1'b1;
        read_ack      <= 1'b1;
        data_out      <= line_mem[address.line.off];
      end
      if (!read_req) begin
        read_ack <= 1'b0;
        data_out <= '0;
        if (write_req || write_en) begin
          line_valid <= 1'b0;  // line may be stale now
        end
      end
    end
  end

endmodule

//--- src/sdram_addr_pkg.sv
package sdram_addr_pkg;

  localparam int addr_w      = 20;  // 1M words
  localparam int line_words  = 4;
  localparam int line_off_w  = 2;
  localparam int block_words = 16;
  localparam int block_off_w = 4;

  localparam int tag_w       = addr_w - line_off_w;   // 18
  localparam int block_num_w = addr_w - block_off_w;  // 16

  typedef struct packed {
    logic [tag_w-1:0]      tag;
    logic [line_off_w-1:0] off;
  } line_view_t;

  typedef struct packed {
    logic [block_num_w-1:0] num;
    logic [block_off_w-1:0] off;
  } block_view_t;

  // same word, read as cache line or as stream block
  typedef union packed {
    line_view_t  line;
    block_view_t block;
  } user_addr_t;

endpackage

//--- src/sdram_ctrl_pkg.sv
package sdram_ctrl_pkg;

  localparam int data_w  = 16;
  localparam int burst_w = 5;
  localparam int beat_w  = 5;  // counts up to a full block

  localparam logic [burst_w-1:0] burst_single = 5'd1;
  localparam logic [burst_w-1:0] burst_line   = 5'd4;
  localparam logic [burst_w-1:0] burst_block  = 5'd16;

endpackage

//--- src/sdram_port_top.sv
module sdram_port_top (
  input  logic                               clk,
  input  logic                               sys_rst_n,
  input  logic [sdram_addr_pkg::addr_w-1:0]  address,
  input  logic [sdram_ctrl_pkg::data_w-1:0]  data_in,
  input  logic                               read_req,
  output logic                               read_ack,
  output logic [sdram_ctrl_pkg::data_w-1:0]  data_out,
  input  logic                               write_req,
  output logic                               write_ack,
  input  logic                               write_latch_address,
  input  logic                               write_en,
  output logic [sdram_addr_pkg::addr_w-1:0]  write_address,
  output logic                               busy,
  output logic                               ctrl_rd_req,
  output logic                               ctrl_wr_req,
  output logic [sdram_addr_pkg::addr_w-1:0]  ctrl_addr,
  output logic [sdram_ctrl_pkg::burst_w-1:0] ctrl_burst,
  output logic [sdram_ctrl_pkg::data_w-1:0]  ctrl_din,
  input  logic                               ctrl_rd_ack,
  input  logic                               ctrl_wr_ack,
  input  logic [sdram_ctrl_pkg::data_w-1:0]  ctrl_dout
);

  logic                                   line_fill_req;
  logic                                   line_fill_done;
  logic                                   fill_we;
  logic [sdram_addr_pkg::line_off_w-1:0]  fill_index;
  logic [sdram_ctrl_pkg::data_w-1:0]      fill_data;
  logic                                   block_req;
  logic                                   block_done;
  logic [sdram_addr_pkg::block_num_w-1:0] block_addr;
  logic [sdram_addr_pkg::block_off_w-1:0] beat_index;
  logic [sdram_ctrl_pkg::data_w-1:0]      beat_data;

  read_line_cache u_cache (
    .clk            (clk),
    .sys_rst_n      (sys_rst_n),
    .address        (address),
    .read_req       (read_req),
    .write_req      (write_req),
    .write_en       (write_en),
    .fill_we        (fill_we),
    .fill_index     (fill_index),
    .fill_data      (fill_data),
    .line_fill_done (line_fill_done),
    .line_fill_req  (line_fill_req),
    .read_ack       (read_ack),
    .data_out       (data_out)
  );

  stream_write_buffer u_stream (
    .clk                 (clk),
    .sys_rst_n           (sys_rst_n),
    .address             (address),
    .data_in             (data_in),
    .write_en            (write_en),
    .write_latch_address (write_latch_address),
    .write_address       (write_address),
    .block_req           (block_req),
    .block_addr          (block_addr),
    .beat_index          (beat_index),
    .beat_data           (beat_data),
    .block_done          (block_done)
  );

  burst_sequencer u_seq (
    .clk            (clk),
    .sys_rst_n      (sys_rst_n),
    .address        (address),
    .data_in        (data_in),
    .write_req      (write_req),
    .write_ack      (write_ack),
    .line_fill_req  (line_fill_req),
    .line_fill_done (line_fill_done),
    .fill_we        (fill_we),
    .fill_index     (fill_index),
    .fill_data      (fill_data),
    .block_req      (block_req),
    .block_addr     (block_addr),
    .beat_index     (beat_index),
    .beat_data      (beat_data),
    .block_done     (block_done),
    .busy           (busy),
    .ctrl_rd_req    (ctrl_rd_req),
    .ctrl_wr_req    (ctrl_wr_req),
    .ctrl_addr      (ctrl_addr),
    .ctrl_burst     (ctrl_burst),
    .ctrl_din       (ctrl_din),
    .ctrl_rd_ack    (ctrl_rd_ack),
    .ctrl_wr_ack    (ctrl_wr_ack),
    .ctrl_dout      (ctrl_dout)
  );

endmodule

//--- src/stream_write_buffer.sv
module stream_write_buffer (
  input  logic                                    clk,
  input  logic                                    sys_rst_n,
  input  sdram_addr_pkg::user_addr_t              address,
  input  logic [sdram_ctrl_pkg::data_w-1:0]       data_in,
  input  logic                                    write_en,
  input  logic                                    write_latch_address,
  output sdram_addr_pkg::user_addr_t              write_address,
  output logic                                    block_req,
  output logic [sdram_addr_pkg::block_num_w-1:0]  block_addr,
  input  logic [sdram_addr_pkg::block_off_w-1:0]  beat_index,
  output logic [sdram_ctrl_pkg::data_w-1:0]       beat_data,
  input  logic                                    block_done
);

  localparam logic [sdram_addr_pkg::block_off_w-1:0] last_off =
    sdram_addr_pkg::block_off_w'(sdram_addr_pkg::block_words - 1);

  // word 15 goes straight to the back buffer, so front holds fifteen
  logic [sdram_ctrl_pkg::data_w-1:0] front_mem [sdram_addr_pkg::block_words-1];
  logic [sdram_ctrl_pkg::data_w-1:0] back_mem  [sdram_addr_pkg::block_words];

  sdram_addr_pkg::user_addr_t wr_cnt;
  sdram_addr_pkg::user_addr_t cur_addr;
  logic                       block_full;

  assign cur_addr      = write_latch_address ? address : wr_cnt;
  assign block_full    = write_en && (cur_addr.block.off == last_off);
  assign write_address = wr_cnt;
  assign beat_data     = back_mem[beat_index];

  always_ff @(posedge clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      wr_cnt    <= '0;
      block_req <= 1'b0;
    end else begin
      if (write_en) begin
        wr_cnt <= sdram_addr_pkg::addr_w'(cur_addr + 1'b1);
      end
      if (block_done) begin
        block_req <= 1'b0;
      end
      if (block_full) begin
        block_req <= 1'b1;  // a new block wins over done
      end
    end
  end

  // payload side
  always_ff @(posedge clk) begin
    if (write_en && !block_full) begin
      front_mem[cur_addr.block.off] <= data_in;
    end
    if (block_full) begin
      for (int i = 0; i < sdram_addr_pkg::block_words - 1; i++) begin
        back_mem[i] <= front_mem[i];
      end
      back_mem[sdram_addr_pkg::block_words-1] <= data_in;
      block_addr <= cur_addr.block.num;
    end
  end

endmodule
